// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Fixed datapath widths
    parameter int ADDR_W = 32;  // Byte address
    parameter int WORD_W = 32;  // Instruction and memory word

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // Front-side request payload, held stable while fetch_req is high
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // Memory request payload
    typedef struct packed {
        addr_t addr;  // Word aligned
    } mem_req_t;

    // One refill word handed from the miss engine to the arrays
    typedef struct packed {
        addr_t addr;  // Word address
        word_t data;
        logic  last;  // Final word of the block
    } fill_word_t;

endpackage

`default_nettype wire

// ==== icache_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_lookup #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                   Clk,
    input  logic                   arst_n,
    input  logic                   fetch_req,
    input  icache_pkg::fetch_req_t fetch,
    input  logic                   resp_idle,
    input  logic                   fill_valid,
    input  icache_pkg::fill_word_t fill,
    output logic                   hit_valid,
    output icache_pkg::word_t      hit_word,
    output logic                   miss_start,
    output icache_pkg::addr_t      miss_addr,
    output logic                   refill_busy
);

    localparam int BYTE_W = $clog2(icache_pkg::WORD_W / 8);
    localparam int OFF_W  = $clog2(BLOCK_WORDS);
    localparam int SET_W  = $clog2(NUM_SETS);
    localparam int WAY_W  = $clog2(NUM_WAYS);
    localparam int TAG_W  = icache_pkg::ADDR_W - SET_W - OFF_W - BYTE_W;

    logic [TAG_W-1:0]  tag_mem  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid  [NUM_SETS];
    icache_pkg::word_t data_mem [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
    logic [WAY_W-1:0]  rr_ptr   [NUM_SETS];  // Next way to evict once the set is full

    logic [TAG_W-1:0]  req_tag, miss_tag;
    logic [SET_W-1:0]  req_set, miss_set;
    logic [OFF_W-1:0]  req_off, miss_off, fill_off;
    logic              accept;
    logic              hit;
    logic              has_free;
    logic [WAY_W-1:0]  hit_way;
    logic [WAY_W-1:0]  victim;
    logic [WAY_W-1:0]  victim_q;
    icache_pkg::word_t target_q;            // Requested word, if it already came in

    // Address split for the incoming fetch and the pending miss
    assign req_tag  = fetch.addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign req_set  = fetch.addr[BYTE_W+OFF_W +: SET_W];
    assign req_off  = fetch.addr[BYTE_W +: OFF_W];
    assign miss_tag = miss_addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign miss_set = miss_addr[BYTE_W+OFF_W +: SET_W];
    assign miss_off = miss_addr[BYTE_W +: OFF_W];
    assign fill_off = fill.addr[BYTE_W +: OFF_W];

    // hit_valid also blocks the cycle before respond leaves idle
    assign accept = fetch_req && resp_idle && !refill_busy && !hit_valid;

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        has_free = 1'b0;
        victim   = rr_ptr[req_set];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid[req_set][w] && tag_mem[req_set][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
            if (!has_free && !valid[req_set][w]) begin  // Lowest invalid way wins
                has_free = 1'b1;
                victim   = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_valid   <= 1'b0;
            miss_start  <= 1'b0;
            refill_busy <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else begin
            hit_valid  <= 1'b0;
            miss_start <= 1'b0;
            if (accept && hit) begin
                hit_valid <= 1'b1;
            end else if (accept) begin
                miss_start  <= 1'b1;
                refill_busy <= 1'b1;
                if (!has_free)
                    rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;
            end
            if (fill_valid && fill.last) begin  // Install, then answer like a hit
                valid[miss_set][victim_q] <= 1'b1;
                refill_busy <= 1'b0;
                hit_valid   <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept && hit)
            hit_word <= data_mem[req_set][hit_way][req_off];
        if (accept && !hit) begin
            miss_addr <= fetch.addr;
            victim_q  <= victim;
        end
        if (fill_valid) begin
            data_mem[miss_set][victim_q][fill_off] <= fill.data;
            if (fill_off == miss_off)
                target_q <= fill.data;
            if (fill.last) begin
                tag_mem[miss_set][victim_q] <= miss_tag;
                hit_word <= (fill_off == miss_off) ? fill.data : target_q;
            end
        end
    end

endmodule

`default_nettype wire

// ==== icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill #(
    parameter int BLOCK_WORDS = 4
) (
    input  logic                   Clk,
    input  logic                   arst_n,
    input  logic                   miss_start,
    input  icache_pkg::addr_t      miss_addr,
    input  logic                   mem_ack,
    input  icache_pkg::word_t      mem_data,
    output logic                   mem_req,
    output icache_pkg::mem_req_t   mem,
    output logic                   fill_valid,
    output icache_pkg::fill_word_t fill
);

    localparam int BYTE_W = $clog2(icache_pkg::WORD_W / 8);
    localparam int OFF_W  = $clog2(BLOCK_WORDS);
    localparam int HI_W   = icache_pkg::ADDR_W - OFF_W - BYTE_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,       // mem_req high, waiting for mem_ack
        ST_WAIT_REL   // mem_req low, waiting for mem_ack to drop
    } state_t;

    state_t           state;
    logic [OFF_W-1:0] word_cnt;
    logic [HI_W-1:0]  blk_hi;   // Tag and set bits of the block being filled
    logic             last_word;

    assign last_word = (word_cnt == OFF_W'(BLOCK_WORDS - 1));

    // Word address walks the block in ascending order
    assign mem.addr = {blk_hi, word_cnt, {BYTE_W{1'b0}}};

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            word_cnt   <= '0;
            mem_req    <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (miss_start) begin
                        word_cnt <= '0;
                        mem_req  <= 1'b1;
                        state    <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= ST_WAIT_REL;
                    end
                end
                ST_WAIT_REL: begin
                    if (!mem_ack) begin
                        fill_valid <= 1'b1;  // Handshake closed, pass the word on
                        if (last_word) begin
                            state <= ST_IDLE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            mem_req  <= 1'b1;
                            state    <= ST_REQ;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == ST_IDLE && miss_start)
            blk_hi <= miss_addr[icache_pkg::ADDR_W-1 -: HI_W];  // Block aligned base
        if (state == ST_REQ && mem_ack) begin
            fill.addr <= mem.addr;
            fill.data <= mem_data;
            fill.last <= last_word;
        end
    end

endmodule

`default_nettype wire

// ==== icache_respond.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_respond (
    input  logic              Clk,
    input  logic              arst_n,
    input  logic              fetch_req,
    input  logic              hit_valid,
    input  icache_pkg::word_t hit_word,
    output logic              fetch_ack,
    output icache_pkg::word_t instr,
    output logic              resp_idle
);

    typedef enum logic {
        ST_IDLE,
        ST_ACKED
    } state_t;

    state_t state;

    // Ack follows the state directly, so it is glitch free
    assign fetch_ack = (state == ST_ACKED);
    assign resp_idle = (state == ST_IDLE);

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hit_valid)
                        state <= ST_ACKED;
                end
                ST_ACKED: begin
                    if (!fetch_req)   // Requester released, close the handshake
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Instruction stays put for as long as the ack is up
    always_ff @(posedge Clk) begin
        if (state == ST_IDLE && hit_valid)
            instr <= hit_word;
    end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                   Clk,
    input  logic                   arst_n,
    input  logic                   fetch_req,
    input  icache_pkg::fetch_req_t fetch,
    output logic                   fetch_ack,
    output icache_pkg::word_t      instr,
    output logic                   mem_req,
    output icache_pkg::mem_req_t   mem,
    input  logic                   mem_ack,
    input  icache_pkg::word_t      mem_data
);

    logic                   resp_idle;
    logic                   hit_valid;
    icache_pkg::word_t      hit_word;
    logic                   miss_start;
    icache_pkg::addr_t      miss_addr;
    logic                   fill_valid;
    icache_pkg::fill_word_t fill;

    // Decode stage with tag compare, arrays and line install
    icache_lookup #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_lookup (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .fetch       (fetch),
        .resp_idle   (resp_idle),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .hit_valid   (hit_valid),
        .hit_word    (hit_word),
        .miss_start  (miss_start),
        .miss_addr   (miss_addr),
        .refill_busy ()
    );

    // Execute stage fetching the block from memory
    icache_refill #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_refill (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .miss_start (miss_start),
        .miss_addr  (miss_addr),
        .mem_ack    (mem_ack),
        .mem_data   (mem_data),
        .mem_req    (mem_req),
        .mem        (mem),
        .fill_valid (fill_valid),
        .fill       (fill)
    );

    // Result stage driving the front-side acknowledge
    icache_respond u_respond (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .hit_valid (hit_valid),
        .hit_word  (hit_word),
        .fetch_ack (fetch_ack),
        .instr     (instr),
        .resp_idle (resp_idle)
    );

endmodule

`default_nettype wire

// ==== icache_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_chk (
    input logic                 Clk,
    input logic                 arst_n,
    input logic                 fetch_req,
    input logic                 fetch_ack,
    input logic                 mem_req,
    input icache_pkg::mem_req_t mem,
    input logic                 mem_ack
);

    // Only the requester may end the front-side handshake
    ack_held: assert property (
        @(posedge Clk) disable iff (!arst_n)
        fetch_ack && fetch_req |=> fetch_ack
    ) else $error("fetch_ack fell while fetch_req was high");

    mem_stable: assert property (
        @(posedge Clk) disable iff (!arst_n)
        mem_req |=> !mem_req || $stable(mem.addr)
    ) else $error("mem changed while mem_req was high");

    // Previous memory handshake has to be closed first
    req_after_release: assert property (
        @(posedge Clk) disable iff (!arst_n)
        !mem_req && mem_ack |=> !mem_req
    ) else $error("mem_req rose while mem_ack was high");

    reset_quiet: assert property (
        @(posedge Clk)
        !arst_n |-> !fetch_ack && !mem_req
    ) else $error("fetch_ack or mem_req high during reset");

endmodule

bind icache_top icache_chk u_chk (
    .Clk       (Clk),
    .arst_n    (arst_n),
    .fetch_req (fetch_req),
    .fetch_ack (fetch_ack),
    .mem_req   (mem_req),
    .mem       (mem),
    .mem_ack   (mem_ack)
);

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 50,  // ns
    parameter int RST_CYCLES  = 3
) (
    input  logic rst_trig,  // Rising edge starts a new reset
    output logic Clk,
    output logic arst_n
);

    initial begin
        Clk = 1'b0;
        forever #(HALF_PERIOD) Clk = ~Clk;
    end

    initial begin
        arst_n = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(posedge Clk);
            @(negedge Clk);
            arst_n = 1'b1;  // Release away from the active edge
            @(posedge rst_trig);
            arst_n = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int BLK_BYTES   = BLOCK_WORDS * 4;
    localparam int NUM_TESTS   = 14;

    typedef struct packed {
        logic [31:0] addr;
        logic        exp_hit;
        logic        reset_first;  // Mid-run reset before the fetch
        logic        rand_hold;    // Hold length drawn from the LFSR
        logic [3:0]  hold;         // Extra cycles with fetch_req held after the ack
    } entry_t;

    logic                   Clk;
    logic                   arst_n;
    logic                   rst_trig  = 1'b0;
    logic                   fetch_req = 1'b0;
    icache_pkg::fetch_req_t fetch     = '0;
    logic                   fetch_ack;
    icache_pkg::word_t      instr;
    logic                   mem_req;
    icache_pkg::mem_req_t   mem;
    logic                   mem_ack   = 1'b0;
    icache_pkg::word_t      mem_data  = '0;

    logic [15:0] mem_lfsr  = 16'd32409;
    logic [15:0] hold_lfsr = 16'd32409;
    int          mem_wait  = -1;  // Cycles left before mem_ack (-1 while no request is open)
    logic [31:0] req_log [$];     // Word addresses requested during the current fetch

    // Reference cache state
    bit          model_valid [NUM_SETS][NUM_WAYS];
    logic [31:0] model_tag   [NUM_SETS][NUM_WAYS];
    int          model_rr    [NUM_SETS];

    int test_err;
    int errors       = 0;
    int failed_tests = 0;

    string names [NUM_TESTS] = '{
        "cold_miss", "hit_same_block", "fill_way1", "fill_way2", "fill_way3",
        "evict_way0", "second_block_hit", "refetch_evicted", "hold_random",
        "hold_fixed", "other_set_miss", "miss_after_reset", "hit_after_reset",
        "other_set_after_reset"
    };

    entry_t stim [NUM_TESTS] = '{
        '{32'h0000_0004, 1'b0, 1'b0, 1'b0, 4'd0},
        '{32'h0000_000C, 1'b1, 1'b0, 1'b0, 4'd0},
        '{32'h0000_0088, 1'b0, 1'b0, 1'b0, 4'd0},  // Same set, next ways
        '{32'h0000_0100, 1'b0, 1'b0, 1'b0, 4'd0},
        '{32'h0000_018C, 1'b0, 1'b0, 1'b0, 4'd0},
        '{32'h0000_0204, 1'b0, 1'b0, 1'b0, 4'd0},  // Set is full so way 0 goes
        '{32'h0000_0084, 1'b1, 1'b0, 1'b0, 4'd0},
        '{32'h0000_0000, 1'b0, 1'b0, 1'b0, 4'd0},
        '{32'h0000_0208, 1'b1, 1'b0, 1'b1, 4'd0},
        '{32'h0000_0104, 1'b1, 1'b0, 1'b0, 4'd3},
        '{32'h1234_5678, 1'b0, 1'b0, 1'b0, 4'd1},
        '{32'h0000_020C, 1'b0, 1'b1, 1'b0, 4'd0},  // Was resident before reset
        '{32'h0000_0200, 1'b1, 1'b0, 1'b0, 4'd0},
        '{32'h1234_5670, 1'b0, 1'b0, 1'b0, 4'd2}   // Set 7 was emptied by the reset
    };

    tb_clkgen clkgen (
        .rst_trig (rst_trig),
        .Clk      (Clk),
        .arst_n   (arst_n)
    );

    icache_top dut (
        .Clk       (Clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .fetch     (fetch),
        .fetch_ack (fetch_ack),
        .instr     (instr),
        .mem_req   (mem_req),
        .mem       (mem),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data)
    );

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic int unsigned take_bits(inout logic [15:0] s, input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
            v = (v << 1) | 32'(s[0]);
        end
        return v;
    endfunction

    // Lookup that installs on a miss into the lowest invalid way or the round-robin way
    function automatic bit model_access(input logic [31:0] a);
        int          s;
        int          victim;
        logic [31:0] t;
        s = int'((a / BLK_BYTES) % NUM_SETS);
        t = a / (BLK_BYTES * NUM_SETS);
        for (int w = 0; w < NUM_WAYS; w++)
            if (model_valid[s][w] && model_tag[s][w] == t)
                return 1'b1;
        victim = -1;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
            if (!model_valid[s][w])
                victim = w;
        if (victim < 0) begin
            victim      = model_rr[s];
            model_rr[s] = (model_rr[s] + 1) % NUM_WAYS;
        end
        model_valid[s][victim] = 1'b1;
        model_tag[s][victim]   = t;
        return 1'b0;
    endfunction

    task automatic check_word(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %h actual %h", name, what, exp, act);
            test_err++;
        end
    endtask

    // Memory model answering one word per four-phase handshake
    always @(negedge Clk) begin
        if (!arst_n) begin
            mem_ack  = 1'b0;
            mem_wait = -1;
        end else if (mem_ack) begin
            if (!mem_req)
                mem_ack = 1'b0;
        end else if (mem_req) begin
            if (mem_wait < 0)
                mem_wait = int'(take_bits(mem_lfsr, 2));
            if (mem_wait == 0) begin
                mem_ack  = 1'b1;
                mem_data = ~mem.addr;
                req_log.push_back(mem.addr);
                mem_wait = -1;
            end else begin
                mem_wait--;
            end
        end
    end

    task automatic apply_reset(input string name);
        @(negedge Clk);
        rst_trig = 1'b1;
        @(posedge arst_n);
        rst_trig = 1'b0;
        @(negedge Clk);
        if (fetch_ack || mem_req) begin
            $display("%s: fetch_ack or mem_req still high after reset", name);
            test_err++;
        end
        foreach (model_valid[s, w])
            model_valid[s][w] = 1'b0;
        foreach (model_rr[s])
            model_rr[s] = 0;
    endtask

    task automatic run_fetch(input string name, input entry_t e);
        logic [31:0]       base;
        icache_pkg::word_t exp_word;
        icache_pkg::word_t held;
        bit                model_hit;
        int                edges;
        int                hold;
        int                exp_reqs;
        base      = e.addr & ~32'(BLK_BYTES - 1);
        exp_word  = ~(e.addr & ~32'h3);
        model_hit = model_access(e.addr);
        exp_reqs  = model_hit ? 0 : BLOCK_WORDS;
        if (model_hit != e.exp_hit) begin
            $display("%s: table hit flag disagrees with the reference model", name);
            test_err++;
        end
        @(negedge Clk);
        req_log.delete();
        fetch.addr = e.addr;
        fetch_req  = 1'b1;
        edges      = 0;
        do begin
            @(negedge Clk);
            edges++;
        end while (!fetch_ack);
        check_word(name, "instr", exp_word, instr);
        if (req_log.size() != exp_reqs) begin
            $display("ERROR %s: memory requests expected %0d actual %0d",
                     name, exp_reqs, req_log.size());
            test_err++;
        end else begin
            foreach (req_log[k])
                check_word(name, "memory address", base + 32'(4 * k), req_log[k]);
        end
        if (model_hit && edges != 2) begin
            $display("ERROR %s: ack latency expected 2 actual %0d", name, edges);
            test_err++;
        end
        hold = e.rand_hold ? 1 + int'(take_bits(hold_lfsr, 2)) : int'(e.hold);
        held = instr;
        repeat (hold) begin
            @(negedge Clk);
            if (!fetch_ack) begin
                $display("%s: fetch_ack dropped while fetch_req was held", name);
                test_err++;
            end
            check_word(name, "held instr", held, instr);
            if (mem_req) begin
                $display("%s: memory request started during back-pressure", name);
                test_err++;
            end
        end
        fetch_req = 1'b0;
        @(negedge Clk);
        if (fetch_ack) begin
            $display("%s: fetch_ack still high one edge after fetch_req dropped", name);
            test_err++;
        end
        while (fetch_ack)
            @(negedge Clk);
    endtask

    initial begin
        @(posedge arst_n);
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_err = 0;
            if (stim[i].reset_first)
                apply_reset(names[i]);
            run_fetch(names[i], stim[i]);
            errors += test_err;
            if (test_err == 0) begin
                $display("test %-18s ok", names[i]);
            end else begin
                failed_tests++;
                $display("test %-18s failed with %0d errors", names[i], test_err);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog allows 40 cycles per table entry
    initial begin
        repeat (NUM_TESTS * 40) @(posedge Clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", NUM_TESTS * 40);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_top.f ====
icache_pkg.sv
icache_lookup.sv
icache_refill.sv
icache_respond.sv
icache_top.sv
icache_chk.sv
tb_clkgen.sv
tb_icache.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= icache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

FAIL_MSG  := STATUS: FAIL
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
